/* simt_mem_cfg.svh */
`ifndef SIMT_MEM_CFG_SVH
`define SIMT_MEM_CFG_SVH

// Threads per warp, also words per memory line.
`define SM_THREADS 8

`define SM_WORD_W 32

// Global lines sit first, shared rows follow them.
`define SM_GLOBAL_LINES 32
`define SM_SHARED_LINES 8

// Wide enough for all 40 lines.
`define SM_LINE_AW 6

`endif

/* simt_mem_pkg.sv */
`include "simt_mem_cfg.svh"

package simt_mem_pkg;

	localparam int LANE_W = $clog2(`SM_THREADS);
	localparam int GLINE_W = $clog2(`SM_GLOBAL_LINES);
	localparam int SROW_W = $clog2(`SM_SHARED_LINES);

	// One memory line, word i at bits 32i+31 down to 32i.
	typedef logic [`SM_THREADS*`SM_WORD_W-1:0] line_data_t;

	typedef struct packed {
		logic [`SM_WORD_W-GLINE_W-LANE_W-1:0] unused;
		logic [GLINE_W-1:0] line;
		logic [LANE_W-1:0] word;
	} global_addr_t;

	// Bank picks the word, row picks the shared line.
	typedef struct packed {
		logic [`SM_WORD_W-SROW_W-LANE_W-1:0] unused;
		logic [SROW_W-1:0] row;
		logic [LANE_W-1:0] bank;
	} shared_addr_t;

	typedef union packed {
		global_addr_t g;
		shared_addr_t s;
		logic [`SM_WORD_W-1:0] raw;
	} thread_addr_u;

endpackage

/* line_mem.sv */
`timescale 1ns/100ps
`include "simt_mem_cfg.svh"

module line_mem
	import simt_mem_pkg::*;
(
	input logic clk,
	input logic en_i,
	input logic we_i,
	input logic [`SM_LINE_AW-1:0] line_i,
	input line_data_t wdata_i,
	input logic [`SM_THREADS-1:0] wen_i,
	output line_data_t rdata_o
);

	localparam int LINES = `SM_GLOBAL_LINES + `SM_SHARED_LINES;

	line_data_t mem_q [LINES];

	// Read returns the old line on a write cycle.
	always_ff @(posedge clk)
	begin
		if (en_i)
		begin
			rdata_o <= mem_q[line_i];
			if (we_i)
			begin
				for (int w = 0; w < `SM_THREADS; w++)
				begin
					if (wen_i[w])
						mem_q[line_i][w*`SM_WORD_W +: `SM_WORD_W] <= wdata_i[w*`SM_WORD_W +: `SM_WORD_W];
				end
			end
		end
	end

endmodule

/* line_mem_arbiter.sv */
`timescale 1ns/100ps
`include "simt_mem_cfg.svh"

module line_mem_arbiter
	import simt_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fio_req_i,
	input logic fio_we_i,
	input logic [`SM_LINE_AW-1:0] fio_line_i,
	input line_data_t fio_wdata_i,
	input logic seq_req_i,
	input logic seq_we_i,
	input logic [`SM_LINE_AW-1:0] seq_line_i,
	input line_data_t seq_wdata_i,
	input logic [`SM_THREADS-1:0] seq_wen_i,
	output logic seq_gnt_o,
	output logic mem_en_o,
	output logic mem_we_o,
	output logic [`SM_LINE_AW-1:0] mem_line_o,
	output line_data_t mem_wdata_o,
	output logic [`SM_THREADS-1:0] mem_wen_o,
	output logic fio_rvalid_o
);

	logic fio_rd_q;

	// Fill port always wins.
	assign seq_gnt_o = seq_req_i && !fio_req_i;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			mem_en_o <= 1'b0;
			mem_we_o <= 1'b0;
			fio_rd_q <= 1'b0;
			fio_rvalid_o <= 1'b0;
		end
		else
		begin
			mem_en_o <= fio_req_i || seq_gnt_o;
			mem_we_o <= fio_req_i ? fio_we_i : seq_we_i;
			// Lines up with the memory's registered read.
			fio_rd_q <= fio_req_i && !fio_we_i;
			fio_rvalid_o <= fio_rd_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fio_req_i)
		begin
			mem_line_o <= fio_line_i;
			mem_wdata_o <= fio_wdata_i;
			mem_wen_o <= '1;
		end
		else if (seq_req_i)
		begin
			mem_line_o <= seq_line_i;
			mem_wdata_o <= seq_wdata_i;
			mem_wen_o <= seq_wen_i;
		end
	end

endmodule

/* lsu_addr_gen.sv */
`timescale 1ns/100ps
`include "simt_mem_cfg.svh"

module lsu_addr_gen
	import simt_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic instr_valid_i,
	input logic mem_write_i,
	input logic shared_i,
	input logic [`SM_THREADS-1:0] thread_mask_i,
	input logic [2:0] warp_id_i,
	input logic [1:0] scb_id_i,
	input line_data_t base_data_i,
	input line_data_t store_data_i,
	input logic [15:0] offset_i,
	input logic [4:0] reg_addr_i,
	input logic done_i,
	output logic busy_o,
	output logic acc_start_o,
	output logic mem_write_o,
	output logic shared_o,
	output logic [`SM_THREADS-1:0] thread_mask_o,
	output logic [2:0] warp_id_o,
	output logic [1:0] scb_id_o,
	output logic [4:0] reg_addr_o,
	output line_data_t store_data_o,
	output thread_addr_u [`SM_THREADS-1:0] addr_o
);

	logic accept;
	line_data_t base_q;
	logic [15:0] offset_q;

	// Issue is ignored while an instruction is in flight.
	assign accept = instr_valid_i && !busy_o;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			busy_o <= 1'b0;
			acc_start_o <= 1'b0;
		end
		else
		begin
			acc_start_o <= accept;
			if (accept)
				busy_o <= 1'b1;
			else if (done_i)
				busy_o <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			mem_write_o <= mem_write_i;
			shared_o <= shared_i;
			thread_mask_o <= thread_mask_i;
			warp_id_o <= warp_id_i;
			scb_id_o <= scb_id_i;
			reg_addr_o <= reg_addr_i;
			store_data_o <= store_data_i;
			base_q <= base_data_i;
			offset_q <= offset_i;
		end
	end

	// Word address per lane, base plus sign-extended offset.
	always_comb
	begin
		for (int i = 0; i < `SM_THREADS; i++)
			addr_o[i].raw = base_q[i*`SM_WORD_W +: `SM_WORD_W] +
				{{(`SM_WORD_W-16){offset_q[15]}}, offset_q};
	end

endmodule

/* lsu_access.sv */
`timescale 1ns/100ps
`include "simt_mem_cfg.svh"

module lsu_access
	import simt_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic acc_start_i,
	input logic mem_write_i,
	input logic shared_i,
	input logic [`SM_THREADS-1:0] thread_mask_i,
	input logic [2:0] warp_id_i,
	input logic [1:0] scb_id_i,
	input logic [4:0] reg_addr_i,
	input line_data_t store_data_i,
	input thread_addr_u [`SM_THREADS-1:0] addr_i,
	output logic req_o,
	output logic we_o,
	output logic [`SM_LINE_AW-1:0] line_o,
	output line_data_t wdata_o,
	output logic [`SM_THREADS-1:0] wen_o,
	input logic gnt_i,
	input line_data_t rdata_i,
	output logic done_o,
	output logic cdb_valid_o,
	output logic [4:0] cdb_reg_addr_o,
	output logic [`SM_THREADS-1:0] cdb_mask_o,
	output line_data_t cdb_data_o,
	output logic [2:0] cdb_warp_id_o,
	output logic [1:0] cdb_scb_id_o,
	output logic fb_valid_o,
	output logic [`SM_THREADS-1:0] fb_mask_o,
	output logic [2:0] fb_warp_id_o,
	output logic [1:0] fb_scb_id_o
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_REQ = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2;
	localparam logic [1:0] S_DATA = 2'd3;

	logic [1:0] state_q;
	logic [`SM_THREADS-1:0] pending_q;
	logic [`SM_THREADS-1:0] hit;
	logic [`SM_THREADS-1:0] remain;
	logic [`SM_LINE_AW-1:0] lane_line [`SM_THREADS];
	logic [LANE_W-1:0] widx [`SM_THREADS];
	logic [`SM_LINE_AW-1:0] lead_line;
	logic found;
	line_data_t result_q;

	// Shared rows live above the global lines.
	always_comb
	begin
		for (int i = 0; i < `SM_THREADS; i++)
		begin
			if (shared_i)
			begin
				lane_line[i] = `SM_LINE_AW'(`SM_GLOBAL_LINES) + `SM_LINE_AW'(addr_i[i].s.row);
				widx[i] = addr_i[i].s.bank;
			end
			else
			begin
				lane_line[i] = `SM_LINE_AW'(addr_i[i].g.line);
				widx[i] = addr_i[i].g.word;
			end
		end
	end

	// Lowest pending lane picks the line for this round.
	always_comb
	begin
		lead_line = '0;
		found = 1'b0;
		for (int i = 0; i < `SM_THREADS; i++)
		begin
			if (pending_q[i] && !found)
			begin
				lead_line = lane_line[i];
				found = 1'b1;
			end
		end
		for (int i = 0; i < `SM_THREADS; i++)
			hit[i] = pending_q[i] && (lane_line[i] == lead_line);
	end

	// Ascending order, so the higher lane wins a shared word.
	always_comb
	begin
		wdata_o = '0;
		wen_o = '0;
		for (int i = 0; i < `SM_THREADS; i++)
		begin
			if (hit[i])
			begin
				wdata_o[widx[i]*`SM_WORD_W +: `SM_WORD_W] = store_data_i[i*`SM_WORD_W +: `SM_WORD_W];
				wen_o[widx[i]] = 1'b1;
			end
		end
	end

	assign remain = pending_q & ~hit;
	assign req_o = (state_q == S_REQ);
	assign we_o = mem_write_i;
	assign line_o = lead_line;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state_q <= S_IDLE;
			pending_q <= '0;
			cdb_valid_o <= 1'b0;
			fb_valid_o <= 1'b0;
		end
		else
		begin
			cdb_valid_o <= 1'b0;
			fb_valid_o <= 1'b0;
			case (state_q)
				S_IDLE:
				begin
					if (acc_start_i)
					begin
						pending_q <= thread_mask_i;
						if (thread_mask_i == '0)
						begin
							cdb_valid_o <= !mem_write_i;
							fb_valid_o <= mem_write_i;
						end
						else
							state_q <= S_REQ;
					end
				end
				S_REQ:
				begin
					if (gnt_i)
						state_q <= S_WAIT;
				end
				S_WAIT:
					state_q <= S_DATA;
				S_DATA:
				begin
					pending_q <= remain;
					if (remain == '0)
					begin
						cdb_valid_o <= !mem_write_i;
						fb_valid_o <= mem_write_i;
						state_q <= S_IDLE;
					end
					else
						state_q <= S_REQ;
				end
				default:
					state_q <= S_IDLE;
			endcase
		end
	end

	// Inactive lanes stay zero from the clear at start.
	always_ff @(posedge clk)
	begin
		if (state_q == S_IDLE && acc_start_i)
			result_q <= '0;
		else if (state_q == S_DATA && !mem_write_i)
		begin
			for (int i = 0; i < `SM_THREADS; i++)
			begin
				if (hit[i])
					result_q[i*`SM_WORD_W +: `SM_WORD_W] <= rdata_i[widx[i]*`SM_WORD_W +: `SM_WORD_W];
			end
		end
	end

	assign done_o = cdb_valid_o | fb_valid_o;
	assign cdb_data_o = result_q;
	assign cdb_reg_addr_o = reg_addr_i;
	assign cdb_mask_o = thread_mask_i;
	assign cdb_warp_id_o = warp_id_i;
	assign cdb_scb_id_o = scb_id_i;
	assign fb_mask_o = thread_mask_i;
	assign fb_warp_id_o = warp_id_i;
	assign fb_scb_id_o = scb_id_i;

endmodule

/* simt_mem_unit.sv */
`timescale 1ns/100ps
`include "simt_mem_cfg.svh"

module simt_mem_unit
	import simt_mem_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic instr_valid_i,
	input logic mem_write_i,
	input logic shared_i,
	input logic [`SM_THREADS-1:0] thread_mask_i,
	input logic [2:0] warp_id_i,
	input logic [1:0] scb_id_i,
	input line_data_t base_data_i,
	input line_data_t store_data_i,
	input logic [15:0] offset_i,
	input logic [4:0] reg_addr_i,
	output logic busy_o,
	input logic fio_req_i,
	input logic fio_we_i,
	input logic [`SM_LINE_AW-1:0] fio_line_i,
	input line_data_t fio_wdata_i,
	output line_data_t fio_rdata_o,
	output logic fio_rvalid_o,
	output logic cdb_valid_o,
	output logic [4:0] cdb_reg_addr_o,
	output logic [`SM_THREADS-1:0] cdb_mask_o,
	output line_data_t cdb_data_o,
	output logic [2:0] cdb_warp_id_o,
	output logic [1:0] cdb_scb_id_o,
	output logic fb_valid_o,
	output logic [`SM_THREADS-1:0] fb_mask_o,
	output logic [2:0] fb_warp_id_o,
	output logic [1:0] fb_scb_id_o
);

	logic acc_start, acc_done, acc_we, acc_shared;
	logic [`SM_THREADS-1:0] acc_mask;
	logic [2:0] acc_warp_id;
	logic [1:0] acc_scb_id;
	logic [4:0] acc_reg_addr;
	line_data_t acc_store_data;
	thread_addr_u [`SM_THREADS-1:0] acc_addr;
	logic seq_req, seq_we, seq_gnt;
	logic [`SM_LINE_AW-1:0] seq_line, mem_line;
	line_data_t seq_wdata, mem_wdata;
	logic [`SM_THREADS-1:0] seq_wen, mem_wen;
	logic mem_en, mem_we;

	lsu_addr_gen i_lsu_addr_gen (
		.clk(clk), .rst(rst), .instr_valid_i(instr_valid_i), .mem_write_i(mem_write_i),
		.shared_i(shared_i), .thread_mask_i(thread_mask_i), .warp_id_i(warp_id_i),
		.scb_id_i(scb_id_i), .base_data_i(base_data_i), .store_data_i(store_data_i),
		.offset_i(offset_i), .reg_addr_i(reg_addr_i), .done_i(acc_done), .busy_o(busy_o),
		.acc_start_o(acc_start), .mem_write_o(acc_we), .shared_o(acc_shared),
		.thread_mask_o(acc_mask), .warp_id_o(acc_warp_id), .scb_id_o(acc_scb_id),
		.reg_addr_o(acc_reg_addr), .store_data_o(acc_store_data), .addr_o(acc_addr)
	);

	lsu_access i_lsu_access (
		.clk(clk), .rst(rst), .acc_start_i(acc_start), .mem_write_i(acc_we),
		.shared_i(acc_shared), .thread_mask_i(acc_mask), .warp_id_i(acc_warp_id),
		.scb_id_i(acc_scb_id), .reg_addr_i(acc_reg_addr), .store_data_i(acc_store_data),
		.addr_i(acc_addr), .req_o(seq_req), .we_o(seq_we), .line_o(seq_line),
		.wdata_o(seq_wdata), .wen_o(seq_wen), .gnt_i(seq_gnt), .rdata_i(fio_rdata_o),
		.done_o(acc_done), .cdb_valid_o(cdb_valid_o), .cdb_reg_addr_o(cdb_reg_addr_o),
		.cdb_mask_o(cdb_mask_o), .cdb_data_o(cdb_data_o), .cdb_warp_id_o(cdb_warp_id_o),
		.cdb_scb_id_o(cdb_scb_id_o), .fb_valid_o(fb_valid_o), .fb_mask_o(fb_mask_o),
		.fb_warp_id_o(fb_warp_id_o), .fb_scb_id_o(fb_scb_id_o)
	);

	line_mem_arbiter i_line_mem_arbiter (
		.clk(clk), .rst(rst), .fio_req_i(fio_req_i), .fio_we_i(fio_we_i),
		.fio_line_i(fio_line_i), .fio_wdata_i(fio_wdata_i), .seq_req_i(seq_req),
		.seq_we_i(seq_we), .seq_line_i(seq_line), .seq_wdata_i(seq_wdata),
		.seq_wen_i(seq_wen), .seq_gnt_o(seq_gnt), .mem_en_o(mem_en), .mem_we_o(mem_we),
		.mem_line_o(mem_line), .mem_wdata_o(mem_wdata), .mem_wen_o(mem_wen),
		.fio_rvalid_o(fio_rvalid_o)
	);

	// Read data goes to both the fill port and the sequencer.
	line_mem i_line_mem (
		.clk(clk), .en_i(mem_en), .we_i(mem_we), .line_i(mem_line),
		.wdata_i(mem_wdata), .wen_i(mem_wen), .rdata_o(fio_rdata_o)
	);

endmodule

/* simt_mem_sva.sv */
`timescale 1ns/100ps

module simt_mem_sva (
	input logic clk,
	input logic rst,
	input logic fio_req,
	input logic seq_gnt,
	input logic mem_en,
	input logic instr_valid,
	input logic busy
);

	// Fill port has priority.
	a_gnt_no_fill: assert property (@(posedge clk) disable iff (!rst)
		!(seq_gnt && fio_req))
		else $error("sequencer granted while a fill request is present");

	a_en_after_req: assert property (@(posedge clk) disable iff (!rst)
		(seq_gnt || fio_req) |=> mem_en)
		else $error("memory enable missing after a grant or fill request");

	a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst)
		!(instr_valid && busy))
		else $error("instruction issued while busy");

endmodule

// Unused inputs are tied off in each binding.
bind line_mem_arbiter simt_mem_sva i_arb_sva (
	.clk(clk), .rst(rst), .fio_req(fio_req_i), .seq_gnt(seq_gnt_o),
	.mem_en(mem_en_o), .instr_valid(1'b0), .busy(1'b0)
);

bind lsu_addr_gen simt_mem_sva i_issue_sva (
	.clk(clk), .rst(rst), .fio_req(1'b0), .seq_gnt(1'b0),
	.mem_en(1'b0), .instr_valid(instr_valid_i), .busy(busy_o)
);

/* tb_simt_mem.sv */
`timescale 1ns/100ps
`include "simt_mem_cfg.svh"

module tb_simt_mem
	import simt_mem_pkg::*;
();

	localparam int LINES = `SM_GLOBAL_LINES + `SM_SHARED_LINES;
	localparam int TIMEOUT = 200;

	logic clk;
	logic rst;
	logic instr_valid_i;
	logic mem_write_i;
	logic shared_i;
	logic [`SM_THREADS-1:0] thread_mask_i;
	logic [2:0] warp_id_i;
	logic [1:0] scb_id_i;
	line_data_t base_data_i;
	line_data_t store_data_i;
	logic [15:0] offset_i;
	logic [4:0] reg_addr_i;
	logic busy_o;
	logic fio_req_i;
	logic fio_we_i;
	logic [`SM_LINE_AW-1:0] fio_line_i;
	line_data_t fio_wdata_i;
	line_data_t fio_rdata_o;
	logic fio_rvalid_o;
	logic cdb_valid_o;
	logic [4:0] cdb_reg_addr_o;
	logic [`SM_THREADS-1:0] cdb_mask_o;
	line_data_t cdb_data_o;
	logic [2:0] cdb_warp_id_o;
	logic [1:0] cdb_scb_id_o;
	logic fb_valid_o;
	logic [`SM_THREADS-1:0] fb_mask_o;
	logic [2:0] fb_warp_id_o;
	logic [1:0] fb_scb_id_o;

	integer seed;
	line_data_t model [LINES];

	simt_mem_unit i_simt_mem_unit (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	function automatic line_data_t rand_line();
		line_data_t d;
		for (int w = 0; w < `SM_THREADS; w++)
			d[w*`SM_WORD_W +: `SM_WORD_W] = rnd();
		return d;
	endfunction

	task automatic report_mismatch(input string what, input line_data_t exp, input line_data_t act);
		$display("** Error at time %0t: %s expected %0h, got %0h", $time, what, exp, act);
		$display("Test failures found");
		$fatal(1, "%s mismatch", what);
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Test failures found");
		$fatal(1, "timeout");
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic fill_write(input int line, input line_data_t d);
		fio_req_i = 1'b1;
		fio_we_i = 1'b1;
		fio_line_i = `SM_LINE_AW'(line);
		fio_wdata_i = d;
		next_cycle();
		fio_req_i = 1'b0;
		fio_we_i = 1'b0;
		model[line] = d;
	endtask

	// Read data shows up exactly two cycles after the request.
	task automatic fill_read_check(input int line);
		fio_req_i = 1'b1;
		fio_we_i = 1'b0;
		fio_line_i = `SM_LINE_AW'(line);
		next_cycle();
		fio_req_i = 1'b0;
		assert (fio_rvalid_o == 1'b0)
			else report_mismatch("early fill read valid", '0, line_data_t'(fio_rvalid_o));
		next_cycle();
		assert (fio_rvalid_o == 1'b1)
			else report_mismatch("fill read valid", line_data_t'(1'b1), line_data_t'(fio_rvalid_o));
		assert (fio_rdata_o == model[line])
			else report_mismatch("fill read data", model[line], fio_rdata_o);
	endtask

	task automatic do_instr(input logic we, input logic sh, input logic traffic, input logic empty);
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] off_ext;
		logic [`SM_THREADS-1:0] mask;
		logic [2:0] warp;
		logic [1:0] scb;
		logic [4:0] rd;
		logic [4:0] cl;
		logic [15:0] off;
		line_data_t base;
		line_data_t sdata;
		line_data_t exp;
		logic [LINES-1:0] used;
		logic h1, h2, done_seen, finished;
		int l1, l2, ln, fl;
		r = rnd();
		mask = empty ? '0 : r[7:0];
		warp = r[10:8];
		scb = r[12:11];
		rd = r[17:13];
		cl = r[22:18];
		r = rnd();
		off = r[15:0];
		off_ext = {{16{off[15]}}, off};
		sdata = rand_line();
		exp = '0;
		used = '0;
		// Lanes cluster on two lines, with random upper bits that must wrap.
		for (int i = 0; i < `SM_THREADS; i++)
		begin
			a = rnd();
			if (sh)
			begin
				a[5:3] = cl[2:0] + {2'b0, a[31]};
				ln = `SM_GLOBAL_LINES + int'(a[5:3]);
			end
			else
			begin
				a[7:3] = cl + {4'b0, a[31]};
				ln = int'(a[7:3]);
			end
			base[i*`SM_WORD_W +: `SM_WORD_W] = a - off_ext;
			if (mask[i])
			begin
				used[ln] = 1'b1;
				if (we)
					model[ln][a[2:0]*`SM_WORD_W +: `SM_WORD_W] = sdata[i*`SM_WORD_W +: `SM_WORD_W];
				else
					exp[i*`SM_WORD_W +: `SM_WORD_W] = model[ln][a[2:0]*`SM_WORD_W +: `SM_WORD_W];
			end
		end
		assert (busy_o == 1'b0)
			else report_mismatch("busy before issue", '0, line_data_t'(busy_o));
		instr_valid_i = 1'b1;
		mem_write_i = we;
		shared_i = sh;
		thread_mask_i = mask;
		warp_id_i = warp;
		scb_id_i = scb;
		base_data_i = base;
		store_data_i = sdata;
		offset_i = off;
		reg_addr_i = rd;
		next_cycle();
		instr_valid_i = 1'b0;
		assert (busy_o == 1'b1)
			else report_mismatch("busy after issue", line_data_t'(1'b1), line_data_t'(busy_o));
		h1 = 1'b0;
		h2 = 1'b0;
		l1 = 0;
		l2 = 0;
		done_seen = 1'b0;
		finished = 1'b0;
		for (int cyc = 0; cyc < TIMEOUT && !finished; cyc++)
		begin
			next_cycle();
			fio_req_i = 1'b0;
			assert (fio_rvalid_o == h2)
				else report_mismatch("fill read valid", line_data_t'(h2), line_data_t'(fio_rvalid_o));
			if (h2)
				assert (fio_rdata_o == model[l2])
					else report_mismatch("fill read data", model[l2], fio_rdata_o);
			h2 = h1;
			l2 = l1;
			h1 = 1'b0;
			if (done_seen)
			begin
				assert (!busy_o && !cdb_valid_o && !fb_valid_o)
					else report_mismatch("busy and pulses after completion", '0,
						line_data_t'({busy_o, cdb_valid_o, fb_valid_o}));
				finished = !h2;
			end
			else if (cdb_valid_o || fb_valid_o)
			begin
				done_seen = 1'b1;
				assert (cdb_valid_o == !we && fb_valid_o == we)
					else report_mismatch("completion kind", line_data_t'({we, !we}),
						line_data_t'({fb_valid_o, cdb_valid_o}));
				if (we)
					assert ({fb_mask_o, fb_warp_id_o, fb_scb_id_o} == {mask, warp, scb})
						else report_mismatch("feedback fields", line_data_t'({mask, warp, scb}),
							line_data_t'({fb_mask_o, fb_warp_id_o, fb_scb_id_o}));
				else
				begin
					assert (cdb_data_o == exp)
						else report_mismatch("load data", exp, cdb_data_o);
					assert ({cdb_mask_o, cdb_warp_id_o, cdb_scb_id_o, cdb_reg_addr_o} ==
						{mask, warp, scb, rd})
						else report_mismatch("bus fields", line_data_t'({mask, warp, scb, rd}),
							line_data_t'({cdb_mask_o, cdb_warp_id_o, cdb_scb_id_o, cdb_reg_addr_o}));
				end
			end
			else
			begin
				r = rnd();
				if (traffic && r[0])
				begin
					// Only lines this instruction leaves alone.
					fl = int'(r[6:1]) % LINES;
					for (int k = 0; k < LINES && used[fl]; k++)
						fl = (fl + 1) % LINES;
					fio_req_i = 1'b1;
					fio_we_i = 1'b0;
					fio_line_i = `SM_LINE_AW'(fl);
					h1 = 1'b1;
					l1 = fl;
				end
			end
		end
		if (!finished)
			report_timeout("load/store completion");
	endtask

	initial
	begin
		logic [31:0] r;
		seed = 32'haa624e33;
		clk = 1'b0;
		rst = 1'b0;
		instr_valid_i = 1'b0;
		mem_write_i = 1'b0;
		shared_i = 1'b0;
		thread_mask_i = '0;
		warp_id_i = '0;
		scb_id_i = '0;
		base_data_i = '0;
		store_data_i = '0;
		offset_i = '0;
		reg_addr_i = '0;
		fio_req_i = 1'b0;
		fio_we_i = 1'b0;
		fio_line_i = '0;
		fio_wdata_i = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;
		assert ({busy_o, cdb_valid_o, fb_valid_o, fio_rvalid_o} == 4'b0)
			else report_mismatch("outputs after reset", '0,
				line_data_t'({busy_o, cdb_valid_o, fb_valid_o, fio_rvalid_o}));

		for (int l = 0; l < LINES; l++)
			fill_write(l, rand_line());
		for (int l = 0; l < LINES; l++)
			fill_read_check(l);

		repeat (30) do_instr(1'b0, 1'b0, 1'b0, 1'b0);
		repeat (30) do_instr(1'b1, 1'b0, 1'b0, 1'b0);
		repeat (40)
		begin
			r = rnd();
			do_instr(r[0], r[1], 1'b0, 1'b0);
		end
		// Shared rows only.
		repeat (30)
		begin
			r = rnd();
			do_instr(r[0], 1'b1, 1'b0, 1'b0);
		end
		repeat (40)
		begin
			r = rnd();
			do_instr(r[0], r[1], 1'b1, 1'b0);
		end
		do_instr(1'b0, 1'b0, 1'b0, 1'b1);
		do_instr(1'b1, 1'b1, 1'b0, 1'b1);

		for (int l = 0; l < LINES; l++)
			fill_read_check(l);

		$display("All tests passed!");
		$finish;
	end

endmodule

/* simt_mem.f */
+incdir+.
simt_mem_pkg.sv
line_mem.sv
line_mem_arbiter.sv
lsu_addr_gen.sv
lsu_access.sv
simt_mem_unit.sv
simt_mem_sva.sv
tb_simt_mem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_simt_mem \
	-f simt_mem.f --Mdir obj_dir -o tb_simt_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_simt_mem_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi

exit 0
